//--- chip_pkg.sv
package chip_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int FLIT_W        = 16;
  localparam int KEY_W         = 12;
  localparam int CREDIT_W      = 4;
  localparam int TAG_PAYLOAD_W = 5;
  localparam int FIFO_DEPTH    = 4;

  localparam int TAG_CNT_W  = $clog2(TAG_PAYLOAD_W);
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  //////////////////////////////
  // Flit encodings
  //////////////////////////////

  localparam logic FLIT_KIND_DATA = 1'b0;
  localparam logic FLIT_KIND_CTRL = 1'b1;

  localparam logic [2:0] OP_SET_KEY   = 3'd1;
  localparam logic [2:0] OP_CLEAR_KEY = 3'd2;

  typedef struct packed {
    logic                link_en;
    logic [CREDIT_W-1:0] credit_max;
  } link_cfg_s;

  typedef struct packed {
    logic              kind;
    logic [FLIT_W-2:0] payload;
  } data_flit_s;

  typedef struct packed {
    logic             kind;
    logic [2:0]       opcode;
    logic [KEY_W-1:0] arg;
  } ctrl_flit_s;

  // Same link word, two views selected by the kind bit
  typedef union packed {
    data_flit_s data;
    ctrl_flit_s ctrl;
  } link_flit_u;

  typedef struct packed {
    logic [FLIT_W-1:0] flit;
  } buf_word_s;

endpackage

//--- tag_client.sv
`timescale 1ns/1ns

module tag_client
  (input  logic                clk_i
  ,input  logic                rst_n_i
  ,input  logic                tag_en_i
  ,input  logic                tag_data_i
  ,output chip_pkg::link_cfg_s cfg_o
  );

  import chip_pkg::*;

  logic                     in_frame_q;
  logic [TAG_CNT_W-1:0]     bit_cnt_q;
  logic [TAG_PAYLOAD_W-2:0] shift_q;
  logic                     bit_v;
  logic                     last_bit;

  // Payload bit present this cycle
  assign bit_v    = in_frame_q & tag_en_i;
  assign last_bit = bit_v & (bit_cnt_q == TAG_CNT_W'(TAG_PAYLOAD_W - 1));

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      in_frame_q <= 1'b0;
      bit_cnt_q  <= '0;
      cfg_o      <= '0;
    end
    else if (tag_en_i)
    begin
      if (!in_frame_q)
      begin
        // Start bit opens a frame
        in_frame_q <= tag_data_i;
        bit_cnt_q  <= '0;
      end
      else if (last_bit)
      begin
        in_frame_q <= 1'b0;
        cfg_o      <= link_cfg_s'({shift_q, tag_data_i});
      end
      else
        bit_cnt_q <= bit_cnt_q + 1'b1;
    end
  end

  // MSB first so earlier bits move up
  always_ff @(posedge clk_i)
  begin
    if (bit_v && !last_bit)
      shift_q <= {shift_q[TAG_PAYLOAD_W-3:0], tag_data_i};
  end

endmodule

//--- link_rx.sv
`timescale 1ns/1ns

module link_rx
  (input  logic                 clk_i
  ,input  logic                 rst_n_i
  ,input  chip_pkg::link_cfg_s  cfg_i
  ,input  logic                 link_v_i
  ,input  chip_pkg::link_flit_u link_data_i
  ,output logic                 link_tkn_o
  ,output logic                 out_req_o
  ,input  logic                 out_ack_i
  ,output chip_pkg::buf_word_s  out_word_o
  );

  import chip_pkg::*;

  link_flit_u       flit_q;
  logic             slot_q;
  logic             req_q;
  logic             tkn_q;
  logic [KEY_W-1:0] key_q;
  logic             capture;
  logic             discard;
  logic             is_ctrl;
  logic             ctrl_done;
  logic             data_done;
  data_flit_s       plain;

  //////////////////////////////
  // Receive slot
  //////////////////////////////

  // Single flit slot
  assign capture = link_v_i & ~slot_q & cfg_i.link_en;
  assign discard = link_v_i & ~slot_q & ~cfg_i.link_en;

  assign is_ctrl   = (flit_q.ctrl.kind == FLIT_KIND_CTRL);
  assign ctrl_done = slot_q & is_ctrl;
  assign data_done = req_q & out_ack_i;

  always_ff @(posedge clk_i)
  begin
    if (capture)
      flit_q <= link_data_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      slot_q <= 1'b0;
      req_q  <= 1'b0;
      tkn_q  <= 1'b0;
      key_q  <= '0;
    end
    else
    begin
      // One token per accepted or discarded flit
      tkn_q <= discard | ctrl_done | data_done;

      if (capture)
        slot_q <= 1'b1;
      else if (ctrl_done || data_done)
        slot_q <= 1'b0;

      if (ctrl_done)
      begin
        if (flit_q.ctrl.opcode == OP_SET_KEY)
          key_q <= flit_q.ctrl.arg;
        else if (flit_q.ctrl.opcode == OP_CLEAR_KEY)
          key_q <= '0;
      end

      // Producer side, new req waits for ack low
      if (data_done)
        req_q <= 1'b0;
      else if (slot_q && !is_ctrl && !req_q && !out_ack_i)
        req_q <= 1'b1;
    end
  end

  //////////////////////////////
  // Descramble
  //////////////////////////////

  always_comb
  begin
    plain.kind               = FLIT_KIND_DATA;
    plain.payload            = flit_q.data.payload;
    plain.payload[KEY_W-1:0] = flit_q.data.payload[KEY_W-1:0] ^ key_q;
  end

  assign out_word_o.flit = plain;
  assign out_req_o       = req_q;
  assign link_tkn_o      = tkn_q;

endmodule

//--- link_fifo.sv
`timescale 1ns/1ns

module link_fifo
  (input  logic                clk_i
  ,input  logic                rst_n_i
  ,input  logic                in_req_i
  ,output logic                in_ack_o
  ,input  chip_pkg::buf_word_s in_word_i
  ,output logic                out_req_o
  ,input  logic                out_ack_i
  ,output chip_pkg::buf_word_s out_word_o
  );

  import chip_pkg::*;

  buf_word_s             mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] count_q;
  logic                  in_ack_q;
  logic                  out_req_q;
  logic                  full;
  logic                  empty;
  logic                  push;
  logic                  pop;

  function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] ptr);
    if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full  = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
  assign empty = (count_q == '0);

  // Write on req edge, pop once the consumer acks
  assign push = in_req_i & ~in_ack_q & ~full;
  assign pop  = out_req_q & out_ack_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      in_ack_q  <= 1'b0;
      out_req_q <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q <= count_q + FIFO_CNT_W'(push) - FIFO_CNT_W'(pop);

      //////////////////////////////
      // Input consumer
      //////////////////////////////
      if (push)
        in_ack_q <= 1'b1;
      else if (in_ack_q && !in_req_i)
        in_ack_q <= 1'b0;

      //////////////////////////////
      // Output producer
      //////////////////////////////
      if (pop)
        out_req_q <= 1'b0;
      else if (!out_req_q && !out_ack_i && !empty)
        out_req_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_q[wr_ptr_q] <= in_word_i;
  end

  // Head entry stays put while req is high
  assign out_word_o = mem_q[rd_ptr_q];
  assign out_req_o  = out_req_q;
  assign in_ack_o   = in_ack_q;

endmodule

//--- link_tx.sv
`timescale 1ns/1ns

module link_tx
  (input  logic                 clk_i
  ,input  logic                 rst_n_i
  ,input  chip_pkg::link_cfg_s  cfg_i
  ,input  logic                 in_req_i
  ,output logic                 in_ack_o
  ,input  chip_pkg::buf_word_s  in_word_i
  ,output logic                 link_v_o
  ,output chip_pkg::link_flit_u link_data_o
  ,input  logic                 link_tkn_i
  );

  import chip_pkg::*;

  link_cfg_s           cfg_q;
  logic [CREDIT_W-1:0] credit_q;
  logic                in_ack_q;
  logic                v_q;
  link_flit_u          data_q;
  logic                cfg_chg;
  logic                can_send;
  logic                take;

  // A new tag frame shows up as a cfg change
  assign cfg_chg  = (cfg_i != cfg_q);
  assign can_send = cfg_i.link_en & (credit_q != '0) & ~cfg_chg;
  assign take     = in_req_i & ~in_ack_q & can_send;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cfg_q    <= '0;
      credit_q <= '0;
      in_ack_q <= 1'b0;
      v_q      <= 1'b0;
    end
    else
    begin
      cfg_q <= cfg_i;
      v_q   <= take;

      //////////////////////////////
      // Credit counter
      //////////////////////////////
      if (cfg_chg)
        credit_q <= cfg_i.credit_max;
      else if (take && !link_tkn_i)
        credit_q <= credit_q - 1'b1;
      else if (link_tkn_i && !take && (credit_q < cfg_i.credit_max))
        credit_q <= credit_q + 1'b1;

      // Consumer side of the buffer handshake
      if (take)
        in_ack_q <= 1'b1;
      else if (in_ack_q && !in_req_i)
        in_ack_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (take)
      data_q <= in_word_i.flit;
  end

  assign in_ack_o    = in_ack_q;
  assign link_v_o    = v_q;
  assign link_data_o = data_q;

endmodule

//--- chip_top.sv
`timescale 1ns/1ns

module chip_top
  (input  logic                 clk_i
  ,input  logic                 rst_n_i
  ,input  logic                 tag_en_i
  ,input  logic                 tag_data_i
  ,input  logic                 link_v_i
  ,input  chip_pkg::link_flit_u link_data_i
  ,output logic                 link_tkn_o
  ,output logic                 link_v_o
  ,output chip_pkg::link_flit_u link_data_o
  ,input  logic                 link_tkn_i
  );

  import chip_pkg::*;

  link_cfg_s cfg;
  logic      rx_req;
  logic      rx_ack;
  buf_word_s rx_word;
  logic      tx_req;
  logic      tx_ack;
  buf_word_s tx_word;

  //////////////////////////////
  // Configuration
  //////////////////////////////

  tag_client i_tag_client
    (.clk_i      ( clk_i      )
    ,.rst_n_i    ( rst_n_i    )
    ,.tag_en_i   ( tag_en_i   )
    ,.tag_data_i ( tag_data_i )
    ,.cfg_o      ( cfg        )
    );

  //////////////////////////////
  // Link datapath
  //////////////////////////////

  link_rx i_link_rx
    (.clk_i       ( clk_i       )
    ,.rst_n_i     ( rst_n_i     )
    ,.cfg_i       ( cfg         )
    ,.link_v_i    ( link_v_i    )
    ,.link_data_i ( link_data_i )
    ,.link_tkn_o  ( link_tkn_o  )
    ,.out_req_o   ( rx_req      )
    ,.out_ack_i   ( rx_ack      )
    ,.out_word_o  ( rx_word     )
    );

  link_fifo i_link_fifo
    (.clk_i      ( clk_i   )
    ,.rst_n_i    ( rst_n_i )
    ,.in_req_i   ( rx_req  )
    ,.in_ack_o   ( rx_ack  )
    ,.in_word_i  ( rx_word )
    ,.out_req_o  ( tx_req  )
    ,.out_ack_i  ( tx_ack  )
    ,.out_word_o ( tx_word )
    );

  link_tx i_link_tx
    (.clk_i       ( clk_i       )
    ,.rst_n_i     ( rst_n_i     )
    ,.cfg_i       ( cfg         )
    ,.in_req_i    ( tx_req      )
    ,.in_ack_o    ( tx_ack      )
    ,.in_word_i   ( tx_word     )
    ,.link_v_o    ( link_v_o    )
    ,.link_data_o ( link_data_o )
    ,.link_tkn_i  ( link_tkn_i  )
    );

endmodule

//--- chip_checker.sv
`timescale 1ns/1ns

module chip_checker
  (input logic                          clk_i
  ,input logic                          rst_n_i
  ,input logic                          req_i
  ,input logic                          ack_i
  ,input logic                          v_i
  ,input logic                          en_i
  ,input logic [chip_pkg::CREDIT_W-1:0]   credit_i
  ,input logic [chip_pkg::FIFO_CNT_W-1:0] count_i
  );

  import chip_pkg::*;

  // Failed assertions, read by the testbench at the end
  int fail_cnt = 0;

  //////////////////////////////
  // Four-phase handshake
  //////////////////////////////

  req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i && !ack_i |=> req_i)
    else
    begin
      $error("req dropped before ack");
      fail_cnt++;
    end

  ack_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_i && req_i |=> ack_i)
    else
    begin
      $error("ack dropped before req fell");
      fail_cnt++;
    end

  // Valid cycle comes from a take with credit and link enabled
  credit_ok: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    v_i |-> ($past(credit_i) != '0) && $past(en_i))
    else
    begin
      $error("link_v_o without credit or with link disabled");
      fail_cnt++;
    end

  occupancy_ok: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_i <= FIFO_CNT_W'(FIFO_DEPTH))
    else
    begin
      $error("buffer occupancy above depth");
      fail_cnt++;
    end

endmodule

bind link_fifo chip_checker i_fifo_checker
  (.clk_i    ( clk_i     )
  ,.rst_n_i  ( rst_n_i   )
  ,.req_i    ( in_req_i  )
  ,.ack_i    ( in_ack_o  )
  ,.v_i      ( 1'b0      )
  ,.en_i     ( 1'b1      )
  ,.credit_i ( '1        )
  ,.count_i  ( count_q   )
  );

bind link_tx chip_checker i_tx_checker
  (.clk_i    ( clk_i          )
  ,.rst_n_i  ( rst_n_i        )
  ,.req_i    ( in_req_i       )
  ,.ack_i    ( in_ack_o       )
  ,.v_i      ( link_v_o       )
  ,.en_i     ( cfg_i.link_en  )
  ,.credit_i ( credit_q       )
  ,.count_i  ( '0             )
  );

//--- chip_tb.sv
`timescale 1ns/1ns

module chip_tb;

  import chip_pkg::*;

  localparam int CLK_PERIOD      = 100;
  localparam int RAND_FLITS      = 60;
  localparam int FLIT_BOUND      = RAND_FLITS + 40;
  localparam int CYCLES_PER_FLIT = 80;

  logic              clk_i = 1'b0;
  logic              rst_n_i;
  logic              tag_en_i;
  logic              tag_data_i;
  logic              link_v_i;
  link_flit_u        link_data_i;
  logic              link_tkn_o;
  logic              link_v_o;
  link_flit_u        link_data_o;
  logic              link_tkn_i;

  integer            seed = 32'he527;
  int                errors = 0;
  int                checks = 0;
  int                out_cnt = 0;
  logic              tkn_random = 1'b0;
  logic              ref_en = 1'b0;
  logic [KEY_W-1:0]  ref_key = '0;
  logic [FLIT_W-1:0] exp_q [$];

  chip_top i_chip_top
    (.clk_i       ( clk_i       )
    ,.rst_n_i     ( rst_n_i     )
    ,.tag_en_i    ( tag_en_i    )
    ,.tag_data_i  ( tag_data_i  )
    ,.link_v_i    ( link_v_i    )
    ,.link_data_i ( link_data_i )
    ,.link_tkn_o  ( link_tkn_o  )
    ,.link_v_o    ( link_v_o    )
    ,.link_data_o ( link_data_o )
    ,.link_tkn_i  ( link_tkn_i  )
    );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Expected output word for a data flit under a given key
  function automatic logic [FLIT_W-1:0] expected_flit(input logic [FLIT_W-1:0] w,
                                                      input logic [KEY_W-1:0] key);
    return {1'b0, w[FLIT_W-2:KEY_W], w[KEY_W-1:0] ^ key};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  //////////////////////////////
  // Sender side
  //////////////////////////////

  task automatic send_tag(input logic en, input logic [CREDIT_W-1:0] cmax);
    logic [TAG_PAYLOAD_W-1:0] bits;
    bits       = {en, cmax};
    tag_en_i   = 1'b1;
    tag_data_i = 1'b1;
    @(negedge clk_i);
    for (int i = TAG_PAYLOAD_W - 1; i >= 0; i--)
    begin
      tag_data_i = bits[i];
      @(negedge clk_i);
    end
    tag_en_i   = 1'b0;
    tag_data_i = 1'b0;
    ref_en     = en;
    repeat (3) @(negedge clk_i);
  endtask

  // Drive one valid cycle and update the reference model
  task automatic drive_valid(input logic [FLIT_W-1:0] w);
    link_flit_u f;
    f           = w;
    link_v_i    = 1'b1;
    link_data_i = f;
    if (ref_en)
    begin
      if (f.ctrl.kind == 1'b0)
        exp_q.push_back(expected_flit(w, ref_key));
      else if (f.ctrl.opcode == 3'd1)
        ref_key = f.ctrl.arg;
      else if (f.ctrl.opcode == 3'd2)
        ref_key = '0;
    end
    @(negedge clk_i);
    link_v_i = 1'b0;
  endtask

  task automatic wait_token();
    while (!link_tkn_o)
      @(negedge clk_i);
  endtask

  task automatic send_flit(input logic [FLIT_W-1:0] w);
    drive_valid(w);
    wait_token();
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0)
      @(negedge clk_i);
    repeat (10) @(negedge clk_i);
  endtask

  always @(negedge clk_i)
  begin
    if (tkn_random)
      link_tkn_i = $random(seed);
    else
      link_tkn_i = 1'b0;
  end

  // Compare every output flit against the reference queue
  always @(negedge clk_i)
  begin
    if (rst_n_i && link_v_o)
    begin
      out_cnt++;
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("Output flit %h appeared at %0t ns with nothing expected", link_data_o, $time);
      end
      else
        check_value("link_data_o", link_data_o, exp_q.pop_front());
    end
  end

  initial
  begin
    #((FLIT_BOUND * CYCLES_PER_FLIT + 500) * CLK_PERIOD);
    $display("Timeout: the run did not finish in time, %0d flits still expected", exp_q.size());
    $display("ERRORS FOUND");
    $finish;
  end

  initial
  begin
    int base;
    int seen;
    logic [31:0] r;
    rst_n_i     = 1'b0;
    tag_en_i    = 1'b0;
    tag_data_i  = 1'b0;
    link_v_i    = 1'b0;
    link_data_i = '0;
    link_tkn_i  = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    repeat (2) @(negedge clk_i);

    // Link disabled after reset so flits are dropped
    send_flit(16'h1234);
    send_flit(16'h0abc);
    repeat (10) @(negedge clk_i);
    check_value("out_cnt", out_cnt, 0);

    send_tag(1'b1, 4'd4);
    tkn_random = 1'b1;
    for (int i = 0; i < 4; i++)
      send_flit(16'h0100 + 16'(i * 16'h0111));
    wait_drain();

    // Scramble key and an ignored opcode
    send_flit({1'b1, 3'd1, 12'ha5c});
    send_flit(16'h7fff);
    send_flit({1'b1, 3'd5, 12'h123});
    send_flit(16'h0f0f);
    send_flit({1'b1, 3'd2, 12'h000});
    send_flit(16'h4321);
    wait_drain();

    ////////////////////////////////
    // Credit limit
    ////////////////////////////////
    tkn_random = 1'b0;
    @(negedge clk_i);
    send_tag(1'b1, 4'd2);
    base = out_cnt;
    for (int i = 0; i < 4; i++)
      send_flit(16'h2000 + 16'(i));
    repeat (20) @(negedge clk_i);
    check_value("out_cnt", out_cnt - base, 2);
    tkn_random = 1'b1;
    wait_drain();

    // Back-pressure leaves the sixth flit in the receiver
    tkn_random = 1'b0;
    @(negedge clk_i);
    send_tag(1'b1, 4'd1);
    for (int i = 0; i < 5; i++)
      send_flit(16'h3000 + 16'(i));
    drive_valid(16'h3005);
    seen = 0;
    repeat (20)
    begin
      if (link_tkn_o)
        seen++;
      @(negedge clk_i);
    end
    check_value("link_tkn_o", seen, 0);
    tkn_random = 1'b1;
    wait_token();
    wait_drain();

    ////////////////////////////////
    // Random traffic
    ////////////////////////////////
    send_tag(1'b1, 4'd3);
    for (int i = 0; i < RAND_FLITS; i++)
    begin
      if (i == RAND_FLITS / 2)
        send_tag(1'b1, 4'($random(seed)) | 4'd1);
      r = $random(seed);
      if (r[2:0] == 3'd0)
        send_flit({1'b1, r[5:3], r[17:6]});
      else
        send_flit({1'b0, r[30:16]});
    end
    wait_drain();

    errors += i_chip_top.i_link_fifo.i_fifo_checker.fail_cnt;
    errors += i_chip_top.i_link_tx.i_tx_checker.fail_cnt;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- list.f
chip_pkg.sv
tag_client.sv
link_rx.sv
link_fifo.sv
link_tx.sv
chip_top.sv
chip_checker.sv
chip_tb.sv
